// ==== elevator_pkg.sv ====
// elevator package with the motor, door and door sensor encodings and default sizes
`default_nettype none

package elevator_pkg;

	// motor command
	typedef enum logic [1:0] {
		ENG_IDLE  = 2'd0,
		ENG_DOWN  = 2'd1,
		ENG_UP    = 2'd2
	} engine_cmd_e;

	// door actuator
	typedef enum logic [1:0] {
		DOOR_IDLE  = 2'd0,    // actuator off
		DOOR_OPEN  = 2'd1,
		DOOR_CLOSE = 2'd2
	} door_cmd_e;

	// door position sensor
	typedef enum logic [1:0] {
		DS_BETWEEN = 2'd0,    // travelling or stopped halfway
		DS_OPEN    = 2'd1,
		DS_CLOSED  = 2'd2
	} door_sense_e;

	// building served by one car
	parameter int DEF_NUM_FLOORS = 8;

	// door hold time at a served floor in clock cycles
	parameter int DEF_DWELL_CYCLES = 16;

endpackage

`default_nettype wire

// ==== elevator_requests.sv ====
// elevator call latches, holds car and hall calls per floor until the floor is served
`timescale 1ns/1ps
`default_nettype none

module elevator_requests #(
	parameter int NUM_FLOORS = elevator_pkg::DEF_NUM_FLOORS,
	localparam int FLOOR_W = $clog2(NUM_FLOORS)
) (
	input  wire                  clk,
	input  wire                  reset,
	input  wire [NUM_FLOORS-1:0] btn_in,
	input  wire [NUM_FLOORS-1:0] btn_up_out,
	input  wire [NUM_FLOORS-1:0] btn_down_out,
	input  wire [FLOOR_W-1:0]    floor,
	input  wire                  serve,
	output logic [NUM_FLOORS-1:0] pending
);

	// no up call from the top floor, no down call from floor 0
	localparam logic [NUM_FLOORS-1:0] UP_OK   = {1'b0, {(NUM_FLOORS-1){1'b1}}};
	localparam logic [NUM_FLOORS-1:0] DOWN_OK = {{(NUM_FLOORS-1){1'b1}}, 1'b0};

	logic [NUM_FLOORS-1:0] car_calls;    // pressed inside the car
	logic [NUM_FLOORS-1:0] up_calls;     // hall up buttons
	logic [NUM_FLOORS-1:0] down_calls;   // hall down buttons
	logic [NUM_FLOORS-1:0] clr_mask;
	logic [NUM_FLOORS-1:0] up_press;
	logic [NUM_FLOORS-1:0] down_press;

	// one-hot of the served floor, empty when not serving
	assign clr_mask = {{(NUM_FLOORS-1){1'b0}}, serve} << floor;

	assign up_press   = btn_up_out & UP_OK;
	assign down_press = btn_down_out & DOWN_OK;

	// clear wins over a press at the same floor
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			car_calls  <= '0;
			up_calls   <= '0;
			down_calls <= '0;
		end else begin
			car_calls  <= (car_calls | btn_in) & ~clr_mask;
			up_calls   <= (up_calls | up_press) & ~clr_mask;
			down_calls <= (down_calls | down_press) & ~clr_mask;
		end
	end

	// any call at a floor makes it a stop candidate
	assign pending = car_calls | up_calls | down_calls;

endmodule

`default_nettype wire

// ==== elevator_position.sv ====
// elevator position tracker, counts floors from the level sensors and drives the display
`timescale 1ns/1ps
`default_nettype none

module elevator_position #(
	parameter int NUM_FLOORS = elevator_pkg::DEF_NUM_FLOORS,
	localparam int FLOOR_W = $clog2(NUM_FLOORS)
) (
	input  wire               clk,
	input  wire               reset,
	input  wire               sensor_up,
	input  wire               sensor_down,
	input  wire               moving,
	input  wire               dir_up,
	output logic [FLOOR_W-1:0] floor,
	output logic               arrive,
	output logic [FLOOR_W-1:0] level_display
);

	localparam logic [FLOOR_W-1:0] TOP_FLOOR = FLOOR_W'(NUM_FLOORS - 1);

	logic               reached;      // car level with a landing
	logic               reached_q;
	logic [FLOOR_W-1:0] floor_q;

	assign reached = sensor_up & sensor_down;

	// only a new level counts, and only while the motor runs
	assign arrive = reached & ~reached_q & moving;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			reached_q <= 1'b0;
		end else begin
			reached_q <= reached;
		end
	end

	// step one landing per arrival, pinned at both ends of the shaft
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			floor_q <= '0;
		end else if (arrive) begin
			if (dir_up && floor_q != TOP_FLOOR) begin
				floor_q <= floor_q + 1'b1;
			end else if (!dir_up && floor_q != '0) begin
				floor_q <= floor_q - 1'b1;
			end
		end
	end

	assign floor         = floor_q;
	assign level_display = floor_q;    // display follows the counter

endmodule

`default_nettype wire

// ==== elevator_door.sv ====
// elevator door sequencer, opens, holds, closes and reopens on obstruction
`timescale 1ns/1ps
`default_nettype none

module elevator_door #(
	parameter int DWELL_CYCLES = elevator_pkg::DEF_DWELL_CYCLES,
	localparam int CNT_W = $clog2(DWELL_CYCLES + 1)
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        door_start,
	input  wire                        open_btn,
	input  wire                        close_btn,
	input  wire                        sensor_inside,
	input  wire                        overload,
	input  wire elevator_pkg::door_sense_e sensor_door,
	output elevator_pkg::door_cmd_e    door,
	output logic                       door_done
);

	import elevator_pkg::*;

	localparam logic [1:0] ST_REST    = 2'd0;
	localparam logic [1:0] ST_OPENING = 2'd1;
	localparam logic [1:0] ST_DWELL   = 2'd2;
	localparam logic [1:0] ST_CLOSING = 2'd3;

	localparam logic [CNT_W-1:0] DWELL_LAST = CNT_W'(DWELL_CYCLES - 1);

	logic [1:0]       state;
	logic [CNT_W-1:0] dwell_cnt;
	logic             blocked;    // someone in the doorway or car too heavy
	logic             reopen;

	assign blocked = sensor_inside | overload;
	assign reopen  = blocked | open_btn;

	// closed with nothing pushing it back open
	assign door_done = (state == ST_CLOSING) && !reopen && (sensor_door == DS_CLOSED);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state     <= ST_REST;
			door      <= DOOR_IDLE;
			dwell_cnt <= '0;
		end else begin
			case (state)
				ST_REST: begin
					// open_btn at rest opens the door at the current landing
					if (door_start || open_btn) begin
						state <= ST_OPENING;
						door  <= DOOR_OPEN;
					end
				end
				ST_OPENING: begin
					if (sensor_door == DS_OPEN) begin
						state     <= ST_DWELL;
						door      <= DOOR_IDLE;
						dwell_cnt <= '0;
					end
				end
				ST_DWELL: begin
					if (reopen) begin
						dwell_cnt <= '0;    // hold the door while blocked
					end else if (close_btn || dwell_cnt == DWELL_LAST) begin
						state <= ST_CLOSING;
						door  <= DOOR_CLOSE;
					end else begin
						dwell_cnt <= dwell_cnt + 1'b1;
					end
				end
				ST_CLOSING: begin
					if (reopen) begin
						state <= ST_OPENING;    // back open, dwell starts again
						door  <= DOOR_OPEN;
					end else if (sensor_door == DS_CLOSED) begin
						state <= ST_REST;
						door  <= DOOR_IDLE;
					end
				end
				default: begin
					state <= ST_REST;
					door  <= DOOR_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== elevator_dispatch.sv ====
// elevator scan dispatcher, picks the travel direction, decides stops and drives the motor
`timescale 1ns/1ps
`default_nettype none

module elevator_dispatch #(
	parameter int NUM_FLOORS = elevator_pkg::DEF_NUM_FLOORS,
	localparam int FLOOR_W = $clog2(NUM_FLOORS)
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire [NUM_FLOORS-1:0]     pending,
	input  wire [FLOOR_W-1:0]        floor,
	input  wire                      arrive,
	input  wire                      door_done,
	output elevator_pkg::engine_cmd_e engine,
	output logic                     moving,
	output logic                     dir_up,
	output logic                     door_start,
	output logic                     serve
);

	import elevator_pkg::*;

	localparam logic [1:0] ST_REST  = 2'd0;    // idle, door closed
	localparam logic [1:0] ST_MOVE  = 2'd1;
	localparam logic [1:0] ST_SERVE = 2'd2;    // stopped, door about to open
	localparam logic [1:0] ST_DOOR  = 2'd3;    // waiting for the door cycle

	localparam logic [FLOOR_W-1:0] TOP_FLOOR = FLOOR_W'(NUM_FLOORS - 1);

	logic [1:0]            state;
	logic                  dir_q;
	logic [NUM_FLOORS-1:0] above_mask;
	logic [NUM_FLOORS-1:0] below_mask;
	logic                  calls_above;
	logic                  calls_below;
	logic                  ahead;
	logic                  behind;
	logic                  here;
	logic                  leave;
	logic                  leave_up;
	logic [FLOOR_W-1:0]    next_floor;
	logic                  stop_next;

	always_comb begin
		for (int i = 0; i < NUM_FLOORS; i++) begin
			above_mask[i] = (i > int'(floor));
			below_mask[i] = (i < int'(floor));
		end
	end

	assign calls_above = |(pending & above_mask);
	assign calls_below = |(pending & below_mask);
	assign here        = pending[floor];

	// scan: keep going while work lies ahead, else turn round
	assign ahead    = dir_q ? calls_above : calls_below;
	assign behind   = dir_q ? calls_below : calls_above;
	assign leave    = ahead | behind;
	assign leave_up = ahead ? dir_q : !dir_q;

	// landing the car reaches on the coming arrive
	assign next_floor = dir_q ? ((floor == TOP_FLOOR) ? floor : floor + 1'b1)
	                          : ((floor == '0) ? floor : floor - 1'b1);

	// stop for a call, and always at the end of the shaft
	assign stop_next = pending[next_floor] ||
	                   (dir_q ? (next_floor == TOP_FLOOR) : (next_floor == '0));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state  <= ST_REST;
			dir_q  <= 1'b1;
			engine <= ENG_IDLE;
		end else begin
			case (state)
				ST_REST: begin
					if (here) begin
						state <= ST_DOOR;    // serve this landing, no move
					end else if (leave) begin
						dir_q  <= leave_up;
						engine <= leave_up ? ENG_UP : ENG_DOWN;
						state  <= ST_MOVE;
					end
				end
				ST_MOVE: begin
					if (arrive && stop_next) begin
						engine <= ENG_IDLE;
						state  <= ST_SERVE;
					end
				end
				ST_SERVE: begin
					state <= ST_DOOR;
				end
				ST_DOOR: begin
					if (door_done) begin
						if (!here && leave) begin
							dir_q  <= leave_up;
							engine <= leave_up ? ENG_UP : ENG_DOWN;
							state  <= ST_MOVE;
						end else begin
							state <= ST_REST;    // new call here reopens from rest
						end
					end
				end
				default: begin
					state  <= ST_REST;
					engine <= ENG_IDLE;
				end
			endcase
		end
	end

	assign moving     = (state == ST_MOVE);
	assign dir_up     = dir_q;
	assign door_start = (state == ST_SERVE) || (state == ST_REST && here);
	assign serve      = door_start;    // calls clear as the door starts

endmodule

`default_nettype wire

// ==== elevator_top.sv ====
// elevator controller top, joins call latches, position, door and dispatch to the building
`timescale 1ns/1ps
`default_nettype none

module elevator_top #(
	parameter int NUM_FLOORS   = elevator_pkg::DEF_NUM_FLOORS,
	parameter int DWELL_CYCLES = elevator_pkg::DEF_DWELL_CYCLES,
	localparam int FLOOR_W = $clog2(NUM_FLOORS)
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        open_btn,
	input  wire                        close_btn,
	input  wire                        overload,
	input  wire                        sensor_up,      // both high at a landing
	input  wire                        sensor_down,
	input  wire                        sensor_inside,
	input  wire elevator_pkg::door_sense_e sensor_door,
	input  wire [NUM_FLOORS-1:0]       btn_in,
	input  wire [NUM_FLOORS-1:0]       btn_up_out,
	input  wire [NUM_FLOORS-1:0]       btn_down_out,
	output elevator_pkg::engine_cmd_e  engine,
	output elevator_pkg::door_cmd_e    door,
	output logic [FLOOR_W-1:0]         level_display
);

	logic [NUM_FLOORS-1:0] pending;
	logic [FLOOR_W-1:0]    floor;
	logic                  arrive;
	logic                  moving;
	logic                  dir_up;
	logic                  door_start;
	logic                  door_done;
	logic                  serve;

	elevator_requests #(.NUM_FLOORS(NUM_FLOORS)) requests_i (
		.clk(clk), .reset(reset),
		.btn_in(btn_in), .btn_up_out(btn_up_out), .btn_down_out(btn_down_out),
		.floor(floor), .serve(serve), .pending(pending)
	);

	elevator_position #(.NUM_FLOORS(NUM_FLOORS)) position_i (
		.clk(clk), .reset(reset),
		.sensor_up(sensor_up), .sensor_down(sensor_down),
		.moving(moving), .dir_up(dir_up),
		.floor(floor), .arrive(arrive), .level_display(level_display)
	);

	elevator_door #(.DWELL_CYCLES(DWELL_CYCLES)) door_i (
		.clk(clk), .reset(reset), .door_start(door_start),
		.open_btn(open_btn), .close_btn(close_btn),
		.sensor_inside(sensor_inside), .overload(overload),
		.sensor_door(sensor_door), .door(door), .door_done(door_done)
	);

	elevator_dispatch #(.NUM_FLOORS(NUM_FLOORS)) dispatch_i (
		.clk(clk), .reset(reset),
		.pending(pending), .floor(floor), .arrive(arrive), .door_done(door_done),
		.engine(engine), .moving(moving), .dir_up(dir_up),
		.door_start(door_start), .serve(serve)
	);

endmodule

`default_nettype wire

// ==== elevator_sva.sv ====
// elevator safety checks on motor, door and display, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module elevator_sva #(
	parameter int NUM_FLOORS = elevator_pkg::DEF_NUM_FLOORS,
	localparam int FLOOR_W = $clog2(NUM_FLOORS)
) (
	input wire                             clk,
	input wire                             reset,
	input wire elevator_pkg::engine_cmd_e  engine,
	input wire elevator_pkg::door_cmd_e    door,
	input wire elevator_pkg::door_sense_e  sensor_door,
	input wire [FLOOR_W-1:0]               level_display
);

	import elevator_pkg::*;

	// motor only behind a closed door
	door_closed_when_moving: assert property (@(posedge clk) disable iff (!reset)
		engine != ENG_IDLE |-> sensor_door == DS_CLOSED)
		else $error("engine running while the door is not closed");

	motor_door_exclusive: assert property (@(posedge clk) disable iff (!reset)
		!(engine != ENG_IDLE && door != DOOR_IDLE))
		else $error("engine and door actuator active together");

	display_in_range: assert property (@(posedge clk) disable iff (!reset)
		level_display < NUM_FLOORS)
		else $error("level_display beyond the top floor");

endmodule

bind elevator_top elevator_sva #(.NUM_FLOORS(NUM_FLOORS)) sva_i (
	.clk(clk), .reset(reset), .engine(engine), .door(door),
	.sensor_door(sensor_door), .level_display(level_display)
);

`default_nettype wire

// ==== tb_elevator.sv ====
// elevator testbench, runs car and door plant models and checks trips, scan order and door handling
`timescale 1ns/1ps
`default_nettype none

module tb_elevator;

	import elevator_pkg::*;

	localparam int NUM_FLOORS     = DEF_NUM_FLOORS;
	localparam int DWELL_CYCLES   = DEF_DWELL_CYCLES;
	localparam int FLOOR_W        = $clog2(NUM_FLOORS);
	localparam int DOOR_TRAVEL    = 3;       // door model steps from closed to open
	localparam int TIMEOUT_CYCLES = 4000;    // well above all five tests together

	logic                  clk;
	logic                  reset;
	logic                  open_btn;
	logic                  close_btn;
	logic                  overload;
	logic                  sensor_up;
	logic                  sensor_down;
	logic                  sensor_inside;
	door_sense_e           sensor_door;
	logic [NUM_FLOORS-1:0] btn_in;
	logic [NUM_FLOORS-1:0] btn_up_out;
	logic [NUM_FLOORS-1:0] btn_down_out;
	engine_cmd_e           engine;
	door_cmd_e             door;
	logic [FLOOR_W-1:0]    level_display;
	integer                seed;
	int                    cycle_count;
	int                    door_pos;    // 0 closed, DOOR_TRAVEL fully open

	elevator_top dut_i (
		.clk(clk), .reset(reset),
		.open_btn(open_btn), .close_btn(close_btn), .overload(overload),
		.sensor_up(sensor_up), .sensor_down(sensor_down),
		.sensor_inside(sensor_inside), .sensor_door(sensor_door),
		.btn_in(btn_in), .btn_up_out(btn_up_out), .btn_down_out(btn_down_out),
		.engine(engine), .door(door), .level_display(level_display)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("error at %0t: %s", $time, what);
			stop_with_failure();
		end
	endtask

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count = cycle_count + 1;
			if (cycle_count == TIMEOUT_CYCLES) begin
				$display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
				stop_with_failure();
			end
		end
	end

	// car plant, one level pulse a few cycles after the motor runs
	initial begin
		int travel;
		seed        = 23;
		sensor_up   = 1'b0;
		sensor_down = 1'b0;
		forever begin
			@(posedge clk);
			if (engine != ENG_IDLE) begin
				travel = 3 + ({$random(seed)} % 6);    // 3 to 8 cycles per landing
				repeat (travel - 1) @(posedge clk);
				sensor_up   <= 1'b1;
				sensor_down <= 1'b1;
				@(posedge clk);
				sensor_up   <= 1'b0;
				sensor_down <= 1'b0;
			end
		end
	end

	// door plant, moves one step per cycle while driven
	initial begin
		door_pos    = 0;
		sensor_door = DS_CLOSED;
		forever begin
			@(posedge clk);
			if (door == DOOR_OPEN && door_pos < DOOR_TRAVEL) begin
				door_pos = door_pos + 1;
			end else if (door == DOOR_CLOSE && door_pos > 0) begin
				door_pos = door_pos - 1;
			end
			if (door_pos == 0) begin
				sensor_door <= DS_CLOSED;
			end else if (door_pos == DOOR_TRAVEL) begin
				sensor_door <= DS_OPEN;
			end else begin
				sensor_door <= DS_BETWEEN;
			end
		end
	end

	function automatic logic [NUM_FLOORS-1:0] one_hot(input int f);
		return NUM_FLOORS'(1) << f;
	endfunction

	task automatic press_buttons(input logic [NUM_FLOORS-1:0] car, up, down);
		btn_in       <= car;
		btn_up_out   <= up;
		btn_down_out <= down;
		@(posedge clk);
		btn_in       <= '0;
		btn_up_out   <= '0;
		btn_down_out <= '0;
	endtask

	task automatic hold_idle(input int cycles);
		repeat (cycles) begin
			check_value("engine", ENG_IDLE, engine);
			check_value("door", DOOR_IDLE, door);
			@(posedge clk);
		end
	endtask

	// motor must stay off until the door command shows up
	task automatic wait_door(input door_cmd_e cmd);
		while (door != cmd) begin
			check_value("engine", ENG_IDLE, engine);
			@(posedge clk);
		end
	endtask

	task automatic wait_closed();
		while (door == DOOR_CLOSE) begin
			check_value("engine", ENG_IDLE, engine);
			@(posedge clk);
		end
		check_value("door", DOOR_IDLE, door);
		check_value("sensor_door", DS_CLOSED, sensor_door);
	endtask

	// full open, dwell, close, with close_btn after close_after dwell cycles if positive
	task automatic door_cycle(input int close_after);
		int held;
		held = 0;
		wait_door(DOOR_OPEN);
		while (door == DOOR_OPEN) begin
			check_value("engine", ENG_IDLE, engine);
			@(posedge clk);
		end
		check_value("door", DOOR_IDLE, door);
		check_value("sensor_door", DS_OPEN, sensor_door);
		while (door == DOOR_IDLE) begin
			held = held + 1;
			close_btn <= (held == close_after);
			check_value("engine", ENG_IDLE, engine);
			@(posedge clk);
		end
		close_btn <= 1'b0;
		check_value("door", DOOR_CLOSE, door);
		if (close_after > 0) begin
			check_true(held < DWELL_CYCLES, "close_btn did not cut the door dwell short");
		end else begin
			check_value("dwell cycles", DWELL_CYCLES, held);
		end
		wait_closed();
	endtask

	// one trip, display steps a landing at a time and the car stops only at target
	task automatic travel_to(input int target, input engine_cmd_e dir);
		int last;
		bit stopped;
		while (engine == ENG_IDLE) begin
			@(posedge clk);
		end
		check_value("engine", dir, engine);
		last    = level_display;
		stopped = 1'b0;
		while (!stopped) begin
			@(posedge clk);
			if (level_display != last) begin
				check_value("level_display", (dir == ENG_UP) ? last + 1 : last - 1,
					level_display);
				last = level_display;
			end
			if (engine == ENG_IDLE) begin
				stopped = 1'b1;
			end else begin
				check_value("engine", dir, engine);
			end
		end
		check_value("level_display", target, level_display);
		@(posedge clk);
		check_value("door", DOOR_OPEN, door);    // door follows the stop by one cycle
	endtask

	task automatic check_reset_state();
		check_value("engine", ENG_IDLE, engine);
		check_value("door", DOOR_IDLE, door);
		check_value("level_display", 0, level_display);
	endtask

	task automatic single_trip();
		press_buttons(one_hot(3), '0, '0);
		travel_to(3, ENG_UP);
		door_cycle(-1);
		hold_idle(8);
	endtask

	// car at 3 heading up, upper call served first
	task automatic scan_order();
		press_buttons(one_hot(1), '0, one_hot(5));
		travel_to(5, ENG_UP);
		door_cycle(-1);
		travel_to(1, ENG_DOWN);
		door_cycle(-1);
		hold_idle(20);
	endtask

	task automatic door_obstruction();
		press_buttons(one_hot(1) | one_hot(4), '0, '0);
		wait_door(DOOR_CLOSE);
		sensor_inside <= 1'b1;
		@(posedge clk);
		sensor_inside <= 1'b0;
		overload      <= 1'b1;
		@(posedge clk);
		check_value("door", DOOR_OPEN, door);
		repeat (3 * DWELL_CYCLES) begin
			check_true(door != DOOR_CLOSE, "door began to close while overload was high");
			check_value("engine", ENG_IDLE, engine);
			@(posedge clk);
		end
		check_value("door", DOOR_IDLE, door);
		check_value("sensor_door", DS_OPEN, sensor_door);
		check_value("level_display", 1, level_display);
		overload <= 1'b0;
		wait_door(DOOR_CLOSE);
		wait_closed();
		travel_to(4, ENG_UP);
		door_cycle(-1);
	endtask

	task automatic calls_at_rest_floor();
		press_buttons('0, one_hot(4), '0);
		door_cycle(-1);
		check_value("level_display", 4, level_display);
		hold_idle(4);
		open_btn <= 1'b1;
		@(posedge clk);
		open_btn <= 1'b0;
		door_cycle(3);
		check_value("level_display", 4, level_display);
		hold_idle(8);
	endtask

	initial begin
		reset         = 1'b0;
		open_btn      = 1'b0;
		close_btn     = 1'b0;
		overload      = 1'b0;
		sensor_inside = 1'b0;
		btn_in        = '0;
		btn_up_out    = '0;
		btn_down_out  = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		check_reset_state();
		single_trip();
		scan_order();
		door_obstruction();
		calls_at_rest_floor();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
elevator_pkg.sv
elevator_requests.sv
elevator_position.sv
elevator_door.sv
elevator_dispatch.sv
elevator_top.sv
elevator_sva.sv
tb_elevator.sv

// ==== Bender.yml ====
package:
  name: elevator

sources:
  - files:
      - elevator_pkg.sv
      - elevator_requests.sv
      - elevator_position.sv
      - elevator_door.sv
      - elevator_dispatch.sv
      - elevator_top.sv
  - target: test
    files:
      - elevator_sva.sv
      - tb_elevator.sv
